/* ex_trace_pkg.sv */
package ex_trace_pkg;

    // Data memory address width, shared by the address type and the interval packing
    localparam int ADDR_W = 32;

    // Timestamp taken from the free-running cycle counter in the recorder
    typedef logic [31:0] cycle_t;

    // Full instruction word as delivered by the decode-stage tracker
    typedef logic [31:0] instr_t;

    // Address seen on the data memory port at grant
    typedef logic [ADDR_W-1:0] addr_t;

    // Queue depths for the record FIFO and the interval FIFO
    localparam int TRACE_DEPTH    = 8;
    localparam int INTERVAL_DEPTH = 8;

    // A packed record is the pass-through flag followed by the instruction word
    localparam int RECORD_W = 1 + $bits(instr_t);

    // A packed interval holds start, end, memory start and memory end,
    // then the grant address and the mem_seen flag
    localparam int INTERVAL_W = 4 * $bits(cycle_t) + ADDR_W + 1;

    // Major opcodes in the low seven bits of the instruction
    localparam logic [6:0] OPCODE_LOAD  = 7'h03;
    localparam logic [6:0] OPCODE_STORE = 7'h23;

endpackage

/* ex_interval_if.sv */
`timescale 1ns/1ps

interface ex_interval_if import ex_trace_pkg::*; ();

    // Head of the interval queue is valid, consumer takes it with pop
    logic   valid;
    logic   pop;

    // Execution window and the memory window inside it
    cycle_t time_start;
    cycle_t time_end;
    cycle_t mem_start;
    cycle_t mem_end;
    addr_t  mem_addr;
    logic   mem_seen;

    modport recorder (
        output valid,
        output time_start,
        output time_end,
        output mem_start,
        output mem_end,
        output mem_addr,
        output mem_seen,
        input  pop
    );

    modport matcher (
        input  valid,
        input  time_start,
        input  time_end,
        input  mem_start,
        input  mem_end,
        input  mem_addr,
        input  mem_seen,
        output pop
    );

endinterface

/* trace_fifo.sv */
`timescale 1ns/1ps

module trace_fifo
#(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
)
(
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic             empty_o,
    output logic [WIDTH-1:0] data_o
);

    logic [WIDTH-1:0]             mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         full;
    logic                         wr_en;
    logic                         rd_en;

    assign full    = (int'(count) == DEPTH);
    assign empty_o = (count == '0);

    // Overflowing pushes are dropped, pops on an empty queue do nothing
    assign wr_en = push_i && !full;
    assign rd_en = pop_i && !empty_o;

    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                // Wrap explicitly so a depth that is not a power of two also works
                if (int'(wr_ptr) == DEPTH - 1)
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                if (int'(rd_ptr) == DEPTH - 1)
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* ex_event_recorder.sv */
`timescale 1ns/1ps

module ex_event_recorder import ex_trace_pkg::*;
(
    input  logic clk,
    input  logic rst_n_i,
    input  logic ex_ready_i,
    input  logic data_mem_req_i,
    input  logic data_mem_grant_i,
    input  addr_t data_mem_addr_i,
    ex_interval_if.recorder itf
);

    cycle_t                 counter;
    logic                   ex_ready_q;
    logic                   req_seen_q;
    logic                   mem_seen_q;

    cycle_t                 time_start_q;
    cycle_t                 time_end_q;
    cycle_t                 mem_start_q;
    cycle_t                 mem_end_q;
    addr_t                  mem_addr_q;

    logic                   open_first;
    logic                   req_seen_cur;
    logic                   mem_seen_cur;
    logic                   grant_hit;
    logic                   push;
    logic [INTERVAL_W-1:0]  push_data;
    logic [INTERVAL_W-1:0]  head_data;
    logic                   head_empty;

    // First busy cycle of a new interval, flags of the previous one no longer count
    assign open_first   = ex_ready_i && !ex_ready_q;
    assign req_seen_cur = req_seen_q && !open_first;
    assign mem_seen_cur = mem_seen_q && !open_first;
    assign grant_hit    = data_mem_req_i && data_mem_grant_i;

    // The interval closes in the first low cycle after a busy run
    assign push = ex_ready_q && !ex_ready_i;

    // Memory fields are reported as zero when the interval never saw a grant
    assign push_data = {
        time_start_q,
        time_end_q,
        mem_seen_q ? mem_start_q : cycle_t'(0),
        mem_seen_q ? mem_end_q   : cycle_t'(0),
        mem_seen_q ? mem_addr_q  : addr_t'(0),
        mem_seen_q
    };

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            counter    <= '0;
            ex_ready_q <= 1'b0;
            req_seen_q <= 1'b0;
            mem_seen_q <= 1'b0;
        end
        else
        begin
            counter    <= counter + 1'b1;
            ex_ready_q <= ex_ready_i;
            if (ex_ready_i)
            begin
                req_seen_q <= req_seen_cur || data_mem_req_i;
                mem_seen_q <= mem_seen_cur || grant_hit;
            end
        end
    end

    // Interval payload, only meaningful once the run has closed
    always_ff @(posedge clk)
    begin
        if (ex_ready_i)
        begin
            if (open_first)
            begin
                time_start_q <= counter;
            end
            time_end_q <= counter;
            if (data_mem_req_i && !req_seen_cur)
            begin
                mem_start_q <= counter;
            end
            if (grant_hit && !mem_seen_cur)
            begin
                mem_end_q  <= counter;
                mem_addr_q <= data_mem_addr_i;
            end
        end
    end

    trace_fifo #(
        .WIDTH (INTERVAL_W),
        .DEPTH (INTERVAL_DEPTH)
    ) u_interval_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (push),
        .data_i  (push_data),
        .pop_i   (itf.pop),
        .empty_o (head_empty),
        .data_o  (head_data)
    );

    assign itf.valid = !head_empty;
    assign {itf.time_start, itf.time_end, itf.mem_start,
            itf.mem_end, itf.mem_addr, itf.mem_seen} = head_data;

endmodule

/* ex_trace_matcher.sv */
`timescale 1ns/1ps

module ex_trace_matcher import ex_trace_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                rec_empty_i,
    input  logic [RECORD_W-1:0] rec_data_i,
    output logic                rec_pop_o,
    ex_interval_if.matcher      itf,
    output logic                ex_valid_o,
    output instr_t              ex_instr_o,
    output logic                ex_is_mem_o,
    output cycle_t              ex_time_start_o,
    output cycle_t              ex_time_end_o,
    output cycle_t              ex_mem_start_o,
    output cycle_t              ex_mem_end_o,
    output addr_t               ex_mem_addr_o
);

    typedef enum logic {
        IDLE,
        EMIT
    } state_e;

    state_e state;

    logic   head_pass;
    instr_t head_instr;
    logic   take;

    instr_t instr_q;
    cycle_t time_start_q;
    cycle_t time_end_q;
    cycle_t mem_start_q;
    cycle_t mem_end_q;
    addr_t  mem_addr_q;
    logic   mem_seen_q;
    logic   keep_mem;

    assign {head_pass, head_instr} = rec_data_i;

    // A record may leave once its interval is there, pass-through records never wait
    assign take      = (state == IDLE) && !rec_empty_i && (head_pass || itf.valid);
    assign rec_pop_o = take;
    assign itf.pop   = take && !head_pass;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (take)
                        state <= EMIT;
                end
                EMIT:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            instr_q <= head_instr;
            if (head_pass)
            begin
                time_start_q <= '0;
                time_end_q   <= '0;
                mem_start_q  <= '0;
                mem_end_q    <= '0;
                mem_addr_q   <= '0;
                mem_seen_q   <= 1'b0;
            end
            else
            begin
                time_start_q <= itf.time_start;
                time_end_q   <= itf.time_end;
                mem_start_q  <= itf.mem_start;
                mem_end_q    <= itf.mem_end;
                mem_addr_q   <= itf.mem_addr;
                mem_seen_q   <= itf.mem_seen;
            end
        end
    end

    // Only loads and stores report the memory window
    assign ex_is_mem_o = (instr_q[6:0] == OPCODE_LOAD) || (instr_q[6:0] == OPCODE_STORE);
    assign keep_mem    = ex_is_mem_o && mem_seen_q;

    assign ex_valid_o      = (state == EMIT);
    assign ex_instr_o      = instr_q;
    assign ex_time_start_o = time_start_q;
    assign ex_time_end_o   = time_end_q;
    assign ex_mem_start_o  = keep_mem ? mem_start_q : cycle_t'(0);
    assign ex_mem_end_o    = keep_mem ? mem_end_q   : cycle_t'(0);
    assign ex_mem_addr_o   = keep_mem ? mem_addr_q  : addr_t'(0);

endmodule

/* ex_tracker_top.sv */
`timescale 1ns/1ps

module ex_tracker_top import ex_trace_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n_i,

    // Records from the decode-stage tracker
    input  logic   id_valid_i,
    input  instr_t id_instr_i,
    input  logic   id_pass_through_i,

    // Execution stage and data memory port of the core
    input  logic   ex_ready_i,
    input  logic   data_mem_req_i,
    input  logic   data_mem_grant_i,
    input  addr_t  data_mem_addr_i,

    // Completed trace records
    output logic   ex_valid_o,
    output instr_t ex_instr_o,
    output logic   ex_is_mem_o,
    output cycle_t ex_time_start_o,
    output cycle_t ex_time_end_o,
    output cycle_t ex_mem_start_o,
    output cycle_t ex_mem_end_o,
    output addr_t  ex_mem_addr_o
);

    logic                rec_empty;
    logic                rec_pop;
    logic [RECORD_W-1:0] rec_data;

    ex_interval_if u_interval_if ();

    // Record queue, filled straight from the decode strobe
    trace_fifo #(
        .WIDTH (RECORD_W),
        .DEPTH (TRACE_DEPTH)
    ) u_record_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (id_valid_i),
        .data_i  ({id_pass_through_i, id_instr_i}),
        .pop_i   (rec_pop),
        .empty_o (rec_empty),
        .data_o  (rec_data)
    );

    ex_event_recorder u_recorder (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .ex_ready_i       (ex_ready_i),
        .data_mem_req_i   (data_mem_req_i),
        .data_mem_grant_i (data_mem_grant_i),
        .data_mem_addr_i  (data_mem_addr_i),
        .itf              (u_interval_if.recorder)
    );

    ex_trace_matcher u_matcher (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rec_empty_i     (rec_empty),
        .rec_data_i      (rec_data),
        .rec_pop_o       (rec_pop),
        .itf             (u_interval_if.matcher),
        .ex_valid_o      (ex_valid_o),
        .ex_instr_o      (ex_instr_o),
        .ex_is_mem_o     (ex_is_mem_o),
        .ex_time_start_o (ex_time_start_o),
        .ex_time_end_o   (ex_time_end_o),
        .ex_mem_start_o  (ex_mem_start_o),
        .ex_mem_end_o    (ex_mem_end_o),
        .ex_mem_addr_o   (ex_mem_addr_o)
    );

endmodule

/* ex_tracker_props.sv */
`timescale 1ns/1ps

module ex_tracker_props import ex_trace_pkg::*;
(
    input logic   clk,
    input logic   rst_n_i,
    input logic   valid_i,
    input cycle_t time_start_i,
    input cycle_t time_end_i
);

    // Number of property violations, watched by the testbench
    int unsigned fail_count = 0;

    // A completed record is a one-cycle strobe
    valid_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        valid_i |=> !valid_i
    )
    else
    begin
        fail_count++;
        $error("ex_valid_o stayed high for two cycles");
    end

    valid_low_after_reset: assert property (
        @(posedge clk)
        $rose(rst_n_i) |-> !valid_i
    )
    else
    begin
        fail_count++;
        $error("ex_valid_o was high right after reset");
    end

    // An interval cannot end before it starts
    time_ordered: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        valid_i |-> (time_end_i >= time_start_i)
    )
    else
    begin
        fail_count++;
        $error("ex_time_end_o is below ex_time_start_o");
    end

endmodule

bind ex_tracker_top ex_tracker_props u_props (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .valid_i      (ex_valid_o),
    .time_start_i (ex_time_start_o),
    .time_end_i   (ex_time_end_o)
);

/* tb_ex_tracker.sv */
`timescale 1ns/1ps

module tb_ex_tracker import ex_trace_pkg::*;
();

    // One recorded execution interval as the reference model sees it
    typedef struct packed {
        cycle_t t_start;
        cycle_t t_end;
        cycle_t m_start;
        cycle_t m_end;
        addr_t  m_addr;
        logic   seen;
    } interval_t;

    logic   clk;
    logic   rst_n_i;
    logic   id_valid_i;
    instr_t id_instr_i;
    logic   id_pass_through_i;
    logic   ex_ready_i;
    logic   data_mem_req_i;
    logic   data_mem_grant_i;
    addr_t  data_mem_addr_i;
    logic   ex_valid_o;
    instr_t ex_instr_o;
    logic   ex_is_mem_o;
    cycle_t ex_time_start_o;
    cycle_t ex_time_end_o;
    cycle_t ex_mem_start_o;
    cycle_t ex_mem_end_o;
    addr_t  ex_mem_addr_o;

    // Mirror of the DUT cycle counter for the window in which inputs are driven
    cycle_t    cyc;
    logic      rec_pass_q [$];
    instr_t    rec_instr_q [$];
    interval_t interval_q [$];
    int        checked;

    ex_tracker_top DUT (.*);

    always #5 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
            fail_run($sformatf("Error at %0t: %s expected %h, got %h",
                               $time, name, expected, actual));
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        cyc = cyc + 1;
    endtask

    task automatic send_record(input logic pass, input instr_t instr);
        id_valid_i        = 1'b1;
        id_instr_i        = instr;
        id_pass_through_i = pass;
        rec_pass_q.push_back(pass);
        rec_instr_q.push_back(instr);
        tick();
        id_valid_i        = 1'b0;
        id_pass_through_i = 1'b0;
    endtask

    // Busy run of len cycles, request from req_at, grant at grant_at (negative means never)
    task automatic run_interval(input int len, input int req_at, input int grant_at);
        interval_t iv;
        iv = '0;
        for (int i = 0; i < len; i++)
        begin
            ex_ready_i       = 1'b1;
            data_mem_req_i   = (req_at >= 0) && (i >= req_at) && (grant_at < 0 || i <= grant_at);
            data_mem_grant_i = (i == grant_at);
            data_mem_addr_i  = $urandom;
            if (i == 0)
                iv.t_start = cyc;
            if (i == req_at)
                iv.m_start = cyc;
            if (i == grant_at)
            begin
                iv.m_end  = cyc;
                iv.m_addr = data_mem_addr_i;
                iv.seen   = 1'b1;
            end
            iv.t_end = cyc;
            tick();
        end
        ex_ready_i       = 1'b0;
        data_mem_req_i   = 1'b0;
        data_mem_grant_i = 1'b0;
        data_mem_addr_i  = '0;
        interval_q.push_back(iv);
        tick();
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        while (rec_pass_q.size() != 0 && waited < limit)
        begin
            tick();
            waited++;
        end
        if (rec_pass_q.size() != 0)
            fail_run($sformatf("No trace record arrived within %0d cycles", limit));
    endtask

    task automatic check_output();
        logic      pass;
        instr_t    instr;
        interval_t iv;
        logic      is_mem;
        logic      keep;
        if (rec_pass_q.size() == 0)
            fail_run("A trace record came out with no instruction sent for it");
        pass  = rec_pass_q.pop_front();
        instr = rec_instr_q.pop_front();
        iv    = '0;
        if (!pass)
        begin
            if (interval_q.size() == 0)
                fail_run("A trace record came out before its execution interval ended");
            iv = interval_q.pop_front();
        end
        is_mem = (instr[6:0] == OPCODE_LOAD) || (instr[6:0] == OPCODE_STORE);
        keep   = is_mem && iv.seen;
        check_field("ex_instr_o", instr, ex_instr_o);
        check_field("ex_is_mem_o", is_mem, ex_is_mem_o);
        check_field("ex_time_start_o", iv.t_start, ex_time_start_o);
        check_field("ex_time_end_o", iv.t_end, ex_time_end_o);
        check_field("ex_mem_start_o", keep ? iv.m_start : '0, ex_mem_start_o);
        check_field("ex_mem_end_o", keep ? iv.m_end : '0, ex_mem_end_o);
        check_field("ex_mem_addr_o", keep ? iv.m_addr : '0, ex_mem_addr_o);
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (rst_n_i === 1'b1 && ex_valid_o === 1'b1)
        begin
            check_output();
            checked = checked + 1;
        end
        if (DUT.u_props.fail_count != 0)
            fail_run("A property on the trace outputs was violated");
    end

    initial
    begin
        instr_t instr;
        int     len;
        int     req_at;
        int     grant_at;
        void'($urandom(32'he3fb));
        clk               = 1'b0;
        rst_n_i           = 1'b0;
        id_valid_i        = 1'b0;
        id_instr_i        = '0;
        id_pass_through_i = 1'b0;
        ex_ready_i        = 1'b0;
        data_mem_req_i    = 1'b0;
        data_mem_grant_i  = 1'b0;
        data_mem_addr_i   = '0;
        checked           = 0;
        cyc               = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        cyc     = '0;

        // Single-cycle ALU op
        send_record(1'b0, 32'h00a58533);
        run_interval(1, -1, -1);
        wait_drained(50);

        // Load with the request mid-interval and a later grant
        send_record(1'b0, 32'h0004a503);
        run_interval(5, 1, 3);
        wait_drained(50);

        // Store that never gets its grant
        send_record(1'b0, 32'h00b4a023);
        run_interval(4, 1, -1);
        wait_drained(50);

        // Non-memory opcode with a grant in its interval
        send_record(1'b0, 32'h00c50593);
        run_interval(3, 0, 1);
        wait_drained(50);

        // Pass-through first, then a load that must still take the next interval
        send_record(1'b1, 32'h00000013);
        send_record(1'b0, 32'h0084a283);
        run_interval(2, 0, 0);
        wait_drained(50);

        // Burst of records ahead of their intervals
        for (int k = 0; k < 6; k++)
        begin
            instr = $urandom;
            case (k % 3)
                0:       instr[6:0] = OPCODE_LOAD;
                1:       instr[6:0] = OPCODE_STORE;
                default: instr[6:0] = 7'h33;
            endcase
            send_record(1'b0, instr);
        end
        for (int k = 0; k < 6; k++)
        begin
            repeat ($urandom_range(3, 0)) tick();
            len      = $urandom_range(4, 1);
            req_at   = $urandom_range(len - 1, 0);
            grant_at = $urandom_range(len - 1, req_at);
            if ($urandom_range(3, 0) == 0)
                grant_at = -1;
            run_interval(len, req_at, grant_at);
        end
        wait_drained(100);

        // One more cycle so the one-cycle property of the last strobe completes
        tick();

        if (rec_pass_q.size() == 0 && interval_q.size() == 0 && checked == 12
            && DUT.u_props.fail_count == 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
        begin
            fail_run("Records or intervals were left unmatched at the end of the run");
        end
    end

endmodule

/* list.f */
ex_trace_pkg.sv
ex_interval_if.sv
trace_fifo.sv
ex_event_recorder.sv
ex_trace_matcher.sv
ex_tracker_top.sv
ex_tracker_props.sv
tb_ex_tracker.sv
